/* hart_cfg_pkg.sv */
// Hart configuration with state encoding, hart id type and id width helper
package hart_cfg_pkg;

    // Widest hart id for up to 8 harts
    localparam int unsigned HART_ID_MAX_W = 3;
    localparam int unsigned HART_MAX = 1 << HART_ID_MAX_W;

    typedef logic [HART_ID_MAX_W-1:0] hart_id_t;

    // Per-hart state in two bits
    typedef enum logic [1:0] {
        HART_IDLE   = 2'd0,
        HART_ACTIVE = 2'd1,
        HART_PEND   = 2'd2     // Waiting on a cache access
    } hart_state_e;

    // Id bits needed for n harts with a minimum of one
    function automatic int unsigned hid_w(input int unsigned n);
        int unsigned w;
        w = 1;
        while ((1 << w) < n) begin
            w = w + 1;
        end
        return w;
    endfunction

    // Bits needed to hold a count of 0..n
    function automatic int unsigned cnt_w(input int unsigned n);
        return hid_w(n + 1);
    endfunction

endpackage

/* hart_evt_pkg.sv */
// Event and control structs for ID commands, cache events and pipeline control
package hart_evt_pkg;

    import hart_cfg_pkg::*;

    // Commands issued from the ID stage
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_START = 2'd1,
        OP_KILL  = 2'd2,
        OP_HALT  = 2'd3
    } hart_op_e;

    // 5 bits
    typedef struct packed {
        hart_op_e op;
        hart_id_t hid;          // Target hart
    } id_cmd_t;

    // One 8-bit event per cache
    typedef struct packed {
        logic     miss;         // Access missed this cycle
        hart_id_t miss_hid;
        logic     fin;          // Outstanding access done
        hart_id_t fin_hid;
    } cache_evt_t;

    // 10-bit control bundle to the pipeline
    typedef struct packed {
        logic     stall;
        logic     ic_flush;
        hart_id_t ic_flush_hid;
        logic     dc_flush;
        hart_id_t dc_flush_hid;
        logic     any_idle;     // A hart can take a start
    } pipe_ctrl_t;

endpackage

/* hart_state.sv */
// Per-hart state registers with command and cache event transitions
`timescale 1ns/1ns

module hart_state
    import hart_cfg_pkg::*;
    import hart_evt_pkg::*;
#(
    parameter int N_HARTS = 4
) (
    input  logic               clk,
    input  logic               i_rst_n,

    input  id_cmd_t            i_id_cmd,
    input  cache_evt_t         i_ic_evt,
    input  cache_evt_t         i_dc_evt,
    input  hart_id_t           i_query_hid,

    output hart_state_e        o_query_state,
    output logic [N_HARTS-1:0] o_active,
    output logic [N_HARTS-1:0] o_pending,
    output logic               o_any_idle
);

    localparam int HID_W = hid_w(N_HARTS);

    hart_state_e        state_q [N_HARTS];
    logic [N_HARTS-1:0] idle_v;

    // Only the low id bits select a hart
    logic [HID_W-1:0]   cmd_hid;
    logic [HID_W-1:0]   ic_miss_hid;
    logic [HID_W-1:0]   ic_fin_hid;
    logic [HID_W-1:0]   dc_miss_hid;
    logic [HID_W-1:0]   dc_fin_hid;
    logic [HID_W-1:0]   query_hid;

    assign cmd_hid     = i_id_cmd.hid[HID_W-1:0];
    assign ic_miss_hid = i_ic_evt.miss_hid[HID_W-1:0];
    assign ic_fin_hid  = i_ic_evt.fin_hid[HID_W-1:0];
    assign dc_miss_hid = i_dc_evt.miss_hid[HID_W-1:0];
    assign dc_fin_hid  = i_dc_evt.fin_hid[HID_W-1:0];
    assign query_hid   = i_query_hid[HID_W-1:0];

    for (genvar h = 0; h < N_HARTS; h++) begin : g_hart
        logic        cmd_hit;
        logic        hit_kill;
        logic        hit_start;
        logic        hit_halt;
        logic        hit_miss;
        logic        hit_fin;
        hart_state_e st_nxt;

        assign cmd_hit   = (cmd_hid == HID_W'(h));
        assign hit_kill  = cmd_hit && (i_id_cmd.op == OP_KILL);
        assign hit_start = cmd_hit && (i_id_cmd.op == OP_START);
        assign hit_halt  = cmd_hit && (i_id_cmd.op == OP_HALT);

        // Either cache can park or release the hart
        assign hit_miss = (i_ic_evt.miss && (ic_miss_hid == HID_W'(h))) ||
                          (i_dc_evt.miss && (dc_miss_hid == HID_W'(h)));
        assign hit_fin  = (i_ic_evt.fin && (ic_fin_hid == HID_W'(h))) ||
                          (i_dc_evt.fin && (dc_fin_hid == HID_W'(h)));

        // Kill > finish > miss > start/halt
        always_comb begin
            st_nxt = state_q[h];
            if (hit_kill) begin
                st_nxt = HART_IDLE;
            end else if (hit_fin && state_q[h] == HART_PEND) begin
                st_nxt = HART_ACTIVE;
            end else if (hit_miss && state_q[h] == HART_ACTIVE) begin
                st_nxt = HART_PEND;
            end else if (hit_start && state_q[h] == HART_IDLE) begin
                st_nxt = HART_ACTIVE;
            end else if (hit_halt && state_q[h] == HART_ACTIVE) begin
                st_nxt = HART_IDLE;
            end
        end

        always_ff @(posedge clk) begin
            if (!i_rst_n) begin
                state_q[h] <= (h == 0) ? HART_ACTIVE : HART_IDLE;   // Boot on hart 0
            end else begin
                state_q[h] <= st_nxt;
            end
        end

        assign o_active[h]  = (state_q[h] == HART_ACTIVE);
        assign o_pending[h] = (state_q[h] == HART_PEND);
        assign idle_v[h]    = (state_q[h] == HART_IDLE);
    end

    assign o_any_idle    = |idle_v;
    assign o_query_state = state_q[query_hid];

endmodule

/* hart_issue_sel.sv */
// Round-robin issue picker over the active harts
`timescale 1ns/1ns

module hart_issue_sel
    import hart_cfg_pkg::*;
#(
    parameter int N_HARTS = 4
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic [N_HARTS-1:0] i_active,
    output logic               o_issue_valid,
    output hart_id_t           o_issue_hid
);

    localparam int HID_W = hid_w(N_HARTS);

    logic [HID_W-1:0]     ptr_q;         // Last issued hart
    logic [2*N_HARTS-1:0] act_dbl;
    logic [N_HARTS-1:0]   act_rot;
    logic [N_HARTS-1:0]   rot_onehot;
    int                   rot_base;
    int                   rot_off;
    int                   sel_id;

    // Search starts just above the last issued hart
    assign rot_base   = int'(ptr_q) + 1;
    assign act_dbl    = {i_active, i_active};
    assign act_rot    = act_dbl[rot_base +: N_HARTS];
    assign rot_onehot = act_rot & (~act_rot + 1'b1);   // Lowest set bit

    // One-hot to offset
    always_comb begin
        rot_off = 0;
        for (int i = 0; i < N_HARTS; i++) begin
            if (rot_onehot[i]) begin
                rot_off = i;
            end
        end
    end

    // Undo the rotation with at most one wrap
    always_comb begin
        sel_id = rot_base + rot_off;
        if (sel_id >= N_HARTS) begin
            sel_id = sel_id - N_HARTS;
        end
    end

    assign o_issue_valid = |i_active;
    assign o_issue_hid   = hart_id_t'(sel_id);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            ptr_q <= HID_W'(N_HARTS - 1);   // Hart 0 goes first
        end else if (o_issue_valid) begin
            ptr_q <= HID_W'(sel_id);
        end
    end

endmodule

/* hart_switch.sv */
// Stall and flush generation for the pipeline
`timescale 1ns/1ns

module hart_switch
    import hart_cfg_pkg::*;
    import hart_evt_pkg::*;
#(
    parameter int N_HARTS = 4
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic [N_HARTS-1:0] i_active,
    input  logic               i_any_idle,
    input  logic               i_is_branch,    // Conditional branch in ID
    input  logic               i_is_load,      // Load in ID
    input  cache_evt_t         i_ic_evt,
    input  cache_evt_t         i_dc_evt,
    output pipe_ctrl_t         o_pipe_ctrl
);

    localparam int HID_W = hid_w(N_HARTS);
    localparam int CNT_W = cnt_w(N_HARTS);

    logic [CNT_W-1:0] n_active;
    logic             stall;
    logic             hazard;

    logic             ic_flush_q;
    hart_id_t         ic_flush_hid_q;
    logic             dc_flush_q;
    hart_id_t         dc_flush_hid_q;

    always_comb begin
        n_active = '0;
        for (int i = 0; i < N_HARTS; i++) begin
            n_active = n_active + CNT_W'(i_active[i]);
        end
    end

    // A lone active hart has nothing to hide a hazard behind
    assign hazard = i_is_branch || i_is_load;
    assign stall  = (n_active == '0) || ((n_active == CNT_W'(1)) && hazard);

    // One-cycle flush after each miss and a zero id between misses
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            ic_flush_q     <= 1'b0;
            ic_flush_hid_q <= '0;
            dc_flush_q     <= 1'b0;
            dc_flush_hid_q <= '0;
        end else begin
            ic_flush_q     <= i_ic_evt.miss;
            ic_flush_hid_q <= i_ic_evt.miss ? hart_id_t'(i_ic_evt.miss_hid[HID_W-1:0]) : '0;
            dc_flush_q     <= i_dc_evt.miss;
            dc_flush_hid_q <= i_dc_evt.miss ? hart_id_t'(i_dc_evt.miss_hid[HID_W-1:0]) : '0;
        end
    end

    always_comb begin
        o_pipe_ctrl              = '0;
        o_pipe_ctrl.stall        = stall;
        o_pipe_ctrl.ic_flush     = ic_flush_q;
        o_pipe_ctrl.ic_flush_hid = ic_flush_hid_q;
        o_pipe_ctrl.dc_flush     = dc_flush_q;
        o_pipe_ctrl.dc_flush_hid = dc_flush_hid_q;
        o_pipe_ctrl.any_idle     = i_any_idle;
    end

endmodule

/* hart_ctrl.sv */
// Hart control top level with state, issue and switch blocks
`timescale 1ns/1ns

module hart_ctrl
    import hart_cfg_pkg::*;
    import hart_evt_pkg::*;
#(
    parameter int N_HARTS = 4
) (
    input  logic        clk,
    input  logic        i_rst_n,

    // ID stage
    input  id_cmd_t     i_id_cmd,
    input  hart_id_t    i_query_hid,
    input  logic        i_is_branch,
    input  logic        i_is_load,
    output hart_state_e o_query_state,

    // Caches
    input  cache_evt_t  i_ic_evt,
    input  cache_evt_t  i_dc_evt,

    // IF stage
    output logic        o_issue_valid,
    output hart_id_t    o_issue_hid,

    output pipe_ctrl_t  o_pipe_ctrl
);

    logic [N_HARTS-1:0] active_v;
    logic               any_idle;

    hart_state #(
        .N_HARTS        (N_HARTS)
    ) i_hart_state (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_id_cmd       (i_id_cmd),
        .i_ic_evt       (i_ic_evt),
        .i_dc_evt       (i_dc_evt),
        .i_query_hid    (i_query_hid),
        .o_query_state  (o_query_state),
        .o_active       (active_v),
        .o_pending      (),             // Readable through the query port
        .o_any_idle     (any_idle)
    );

    hart_issue_sel #(
        .N_HARTS        (N_HARTS)
    ) i_hart_issue_sel (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_active       (active_v),
        .o_issue_valid  (o_issue_valid),
        .o_issue_hid    (o_issue_hid)
    );

    hart_switch #(
        .N_HARTS        (N_HARTS)
    ) i_hart_switch (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_active       (active_v),
        .i_any_idle     (any_idle),
        .i_is_branch    (i_is_branch),
        .i_is_load      (i_is_load),
        .i_ic_evt       (i_ic_evt),
        .i_dc_evt       (i_dc_evt),
        .o_pipe_ctrl    (o_pipe_ctrl)
    );

endmodule

/* tb_hart_ctrl.sv */
// Testbench for hart_ctrl with reference model, per-cycle checks, directed and random tests
`timescale 1ns/1ns

module tb_hart_ctrl
    import hart_cfg_pkg::*;
    import hart_evt_pkg::*;
;

    localparam int N_HARTS        = 4;
    localparam int RAND_CYCLES    = 500;
    localparam int DIRECTED_BUDGET = 500;   // Upper bound for tests 1 to 5
    localparam int TIMEOUT_CYCLES = 2 * (RAND_CYCLES + DIRECTED_BUDGET);

    logic        clk;
    logic        rst_n;
    id_cmd_t     id_cmd;
    hart_id_t    query_hid;
    logic        is_branch;
    logic        is_load;
    cache_evt_t  ic_evt;
    cache_evt_t  dc_evt;
    hart_state_e query_state;
    logic        issue_valid;
    hart_id_t    issue_hid;
    pipe_ctrl_t  pipe_ctrl;

    // Reference model state
    hart_state_e m_state [N_HARTS];
    int          m_ptr;
    logic        m_ic_flush;
    hart_id_t    m_ic_hid;
    logic        m_dc_flush;
    hart_id_t    m_dc_hid;
    logic        checking;

    int err_cnt;
    int n_checks;
    int tests_run;
    int tests_failed;
    int test_err0;
    int q_rot;
    int cycles;
    int unsigned seed_val;

    hart_ctrl #(
        .N_HARTS       (N_HARTS)
    ) i_dut (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_id_cmd      (id_cmd),
        .i_query_hid   (query_hid),
        .i_is_branch   (is_branch),
        .i_is_load     (is_load),
        .o_query_state (query_state),
        .i_ic_evt      (ic_evt),
        .i_dc_evt      (dc_evt),
        .o_issue_valid (issue_valid),
        .o_issue_hid   (issue_hid),
        .o_pipe_ctrl   (pipe_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic id_cmd_t cmd_of(input hart_op_e op, input int hid);
        id_cmd_t c;
        c.op  = op;
        c.hid = hart_id_t'(hid);
        return c;
    endfunction

    function automatic cache_evt_t evt_of(input logic miss, input int mhid,
                                          input logic fin, input int fhid);
        cache_evt_t e;
        e.miss     = miss;
        e.miss_hid = hart_id_t'(mhid);
        e.fin      = fin;
        e.fin_hid  = hart_id_t'(fhid);
        return e;
    endfunction

    function automatic int count_active();
        int n;
        n = 0;
        for (int h = 0; h < N_HARTS; h++) begin
            if (m_state[h] == HART_ACTIVE) n++;
        end
        return n;
    endfunction

    function automatic logic idle_present();
        logic any;
        any = 1'b0;
        for (int h = 0; h < N_HARTS; h++) begin
            if (m_state[h] == HART_IDLE) any = 1'b1;
        end
        return any;
    endfunction

    // First active hart above the pointer with wraparound
    function automatic int expected_issue();
        int   h;
        int   pick;
        logic found;
        pick  = 0;
        found = 1'b0;
        for (int k = 1; k <= N_HARTS; k++) begin
            h = (m_ptr + k) % N_HARTS;
            if (!found && m_state[h] == HART_ACTIVE) begin
                pick  = h;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    // Next state of hart h with kill first, then finish, miss and start/halt
    function automatic hart_state_e step_hart(input int h);
        hart_state_e cur;
        logic        hit;
        logic        miss;
        logic        fin;
        cur  = m_state[h];
        hit  = (int'(id_cmd.hid) == h);
        miss = (ic_evt.miss && int'(ic_evt.miss_hid) == h) ||
               (dc_evt.miss && int'(dc_evt.miss_hid) == h);
        fin  = (ic_evt.fin && int'(ic_evt.fin_hid) == h) ||
               (dc_evt.fin && int'(dc_evt.fin_hid) == h);
        if (hit && id_cmd.op == OP_KILL) return HART_IDLE;
        if (fin && cur == HART_PEND) return HART_ACTIVE;
        if (miss && cur == HART_ACTIVE) return HART_PEND;
        if (hit && id_cmd.op == OP_START && cur == HART_IDLE) return HART_ACTIVE;
        if (hit && id_cmd.op == OP_HALT && cur == HART_ACTIVE) return HART_IDLE;
        return cur;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int h = 0; h < N_HARTS; h++) begin
                m_state[h] <= (h == 0) ? HART_ACTIVE : HART_IDLE;
            end
            m_ptr      <= N_HARTS - 1;
            m_ic_flush <= 1'b0;
            m_dc_flush <= 1'b0;
            checking   <= 1'b1;
        end else begin
            for (int h = 0; h < N_HARTS; h++) begin
                m_state[h] <= step_hart(h);
            end
            if (count_active() > 0) m_ptr <= expected_issue();
            m_ic_flush <= ic_evt.miss;
            m_ic_hid   <= ic_evt.miss_hid;
            m_dc_flush <= dc_evt.miss;
            m_dc_hid   <= dc_evt.miss_hid;
        end
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            n_checks++;
            assert (query_state == m_state[query_hid])
                else report_error($sformatf("hart %0d state %0d, expected %0d",
                                            query_hid, query_state, m_state[query_hid]));
            assert (issue_valid == (count_active() > 0))
                else report_error($sformatf("issue valid %0b, wrong", issue_valid));
            assert (!issue_valid || int'(issue_hid) == expected_issue())
                else report_error($sformatf("issue hid %0d, expected %0d",
                                            issue_hid, expected_issue()));
            assert (pipe_ctrl.stall == ((count_active() == 0) ||
                    (count_active() == 1 && (is_branch || is_load))))
                else report_error($sformatf("stall %0b with %0d active harts",
                                            pipe_ctrl.stall, count_active()));
            assert (pipe_ctrl.ic_flush == m_ic_flush &&
                    (!m_ic_flush || pipe_ctrl.ic_flush_hid == m_ic_hid))
                else report_error("i-cache flush pulse or hart id wrong");
            assert (pipe_ctrl.dc_flush == m_dc_flush &&
                    (!m_dc_flush || pipe_ctrl.dc_flush_hid == m_dc_hid))
                else report_error("d-cache flush pulse or hart id wrong");
            assert (pipe_ctrl.any_idle == idle_present())
                else report_error($sformatf("any_idle %0b, wrong", pipe_ctrl.any_idle));
        end
    end

    // One cycle of inputs with the query id rotating over all harts
    task automatic drive(input id_cmd_t cmd, input cache_evt_t ic, input cache_evt_t dc,
                         input logic br, input logic ld);
        @(posedge clk);
        id_cmd    <= cmd;
        ic_evt    <= ic;
        dc_evt    <= dc;
        is_branch <= br;
        is_load   <= ld;
        query_hid <= hart_id_t'(q_rot % N_HARTS);
        q_rot++;
    endtask

    task automatic quiet(input int n);
        repeat (n) drive(cmd_of(OP_NONE, 0), '0, '0, 1'b0, 1'b0);
    endtask

    task automatic command(input hart_op_e op, input int hid);
        drive(cmd_of(op, hid), '0, '0, 1'b0, 1'b0);
        quiet(N_HARTS);
    endtask

    task automatic start_test();
        test_err0 = err_cnt;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt != test_err0) tests_failed++;
        $display("%s: %s (%0d errors)", name, (err_cnt == test_err0) ? "ok" : "FAILED",
                 err_cnt - test_err0);
    endtask

    task automatic random_run();
        hart_op_e op;
        logic     ic_miss;
        logic     dc_miss;
        logic     ic_fin;
        logic     dc_fin;
        repeat (RAND_CYCLES) begin
            op      = hart_op_e'($urandom_range(0, 3));
            ic_miss = ($urandom_range(0, 3) == 0);
            dc_miss = ($urandom_range(0, 3) == 0);
            ic_fin  = ($urandom_range(0, 2) == 0);
            dc_fin  = ($urandom_range(0, 2) == 0);
            drive(cmd_of(op, $urandom_range(0, N_HARTS - 1)),
                  evt_of(ic_miss, $urandom_range(0, N_HARTS - 1),
                         ic_fin, $urandom_range(0, N_HARTS - 1)),
                  evt_of(dc_miss, $urandom_range(0, N_HARTS - 1),
                         dc_fin, $urandom_range(0, N_HARTS - 1)),
                  1'(($urandom_range(0, 3) == 0)), 1'(($urandom_range(0, 3) == 0)));
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    initial begin
        seed_val     = $urandom(31);
        rst_n        = 1'b0;
        id_cmd       = '0;
        query_hid    = '0;
        is_branch    = 1'b0;
        is_load      = 1'b0;
        ic_evt       = '0;
        dc_evt       = '0;
        checking     = 1'b0;
        err_cnt      = 0;
        n_checks     = 0;
        tests_run    = 0;
        tests_failed = 0;
        q_rot        = 0;

        start_test();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        quiet(N_HARTS + 1);
        end_test("reset");

        start_test();
        command(OP_START, 1);
        command(OP_START, 1);                       // Already active
        command(OP_HALT, 2);                        // No effect on an idle hart
        command(OP_HALT, 1);
        command(OP_START, 2);
        command(OP_KILL, 2);
        command(OP_START, 3);
        drive(cmd_of(OP_NONE, 0), evt_of(1'b1, 3, 1'b0, 0), '0, 1'b0, 1'b0);
        drive(cmd_of(OP_KILL, 3), evt_of(1'b0, 0, 1'b1, 3), '0, 1'b0, 1'b0);
        quiet(N_HARTS);
        end_test("commands");

        start_test();
        command(OP_START, 1);
        command(OP_START, 2);
        drive(cmd_of(OP_NONE, 0), evt_of(1'b1, 1, 1'b0, 0), evt_of(1'b1, 2, 1'b0, 0),
              1'b0, 1'b0);
        quiet(N_HARTS);
        drive(cmd_of(OP_NONE, 0), evt_of(1'b1, 3, 1'b1, 1), evt_of(1'b0, 0, 1'b1, 2),
              1'b0, 1'b0);                      // Miss on idle hart 3
        quiet(N_HARTS);
        end_test("cache events");

        start_test();
        command(OP_START, 3);
        quiet(2 * N_HARTS);
        drive(cmd_of(OP_HALT, 1), '0, evt_of(1'b1, 2, 1'b0, 0), 1'b0, 1'b0);
        quiet(2 * N_HARTS);
        for (int h = 0; h < N_HARTS; h++) command(OP_KILL, h);
        end_test("issue order");

        start_test();
        drive(cmd_of(OP_NONE, 0), '0, '0, 1'b1, 1'b0);
        command(OP_START, 0);
        drive(cmd_of(OP_NONE, 0), '0, '0, 1'b1, 1'b0);
        drive(cmd_of(OP_NONE, 0), '0, '0, 1'b0, 1'b1);
        drive(cmd_of(OP_NONE, 0), '0, '0, 1'b0, 1'b0);
        command(OP_START, 1);
        drive(cmd_of(OP_NONE, 0), '0, '0, 1'b1, 1'b1);
        drive(cmd_of(OP_NONE, 0), '0, evt_of(1'b1, 1, 1'b0, 0), 1'b0, 1'b1);
        drive(cmd_of(OP_NONE, 0), evt_of(1'b1, 0, 1'b0, 0), '0, 1'b0, 1'b1);
        quiet(N_HARTS);                         // All pending
        drive(cmd_of(OP_NONE, 0), evt_of(1'b0, 0, 1'b1, 0), evt_of(1'b0, 0, 1'b1, 1),
              1'b1, 1'b0);
        quiet(N_HARTS);
        end_test("stall");

        start_test();
        random_run();
        quiet(2);
        end_test("random run");

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, n_checks, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* hart_ctrl.f */
hart_cfg_pkg.sv
hart_evt_pkg.sv
hart_state.sv
hart_issue_sel.sv
hart_switch.sv
hart_ctrl.sv
tb_hart_ctrl.sv

/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := tb_hart_ctrl
FLIST := hart_ctrl.f
LOG   := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
